//--- all.f
verilog/cpuSmPkg.sv
verilog/cpuSmTermsIf.sv
verilog/cpuSm.sv
verilog/cpuSmOutputs.sv
verilog/dmaFifo.sv
verilog/addrCounter.sv
verilog/sdmacCpuTop.sv
verification/sdmacCpuTb.sv

//--- run.sh
#!/bin/sh
# Build the simulation with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module sdmacCpuTb --Mdir obj_dir -o sdmacCpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sdmacCpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- verification/sdmacCpuTb.sv
// Testbench with clock, arbiter and memory bus model, reference pattern, stimulus and checks
`timescale 1ns/1ps

module sdmacCpuTb import cpuSmPkg::*; ();

    // DUT inputs and their idle values
    logic       clk        = 1'b0;
    logic       rstN       = 1'b0;
    logic       start      = 1'b0;
    logic       dirRead    = 1'b0;
    busAddr_t   startAddr  = '0;
    wordCount_t startCount = '0;
    logic       scsiPush   = 1'b0;
    dataWord_t  scsiWrData = '0;
    logic       scsiPop    = 1'b0;
    logic       bgN        = 1'b1;
    logic       dsackN     = 1'b1;
    logic       stermN     = 1'b1;
    dataWord_t  rdData     = '0;

    dataWord_t  scsiRdData;
    logic       breqN;
    logic       bgackN;
    logic       asN;
    logic       dsN;
    logic       rw;
    busAddr_t   addr;
    dataWord_t  wrData;
    logic       done;
    logic       fifoFull;
    logic       fifoEmpty;

    // Bus model state
    dataWord_t   mem [256];
    integer      seed = 32'hb9d4_c63b;
    logic [31:0] randVal;
    logic [1:0]  grantDelay;
    int          grantState;
    logic        ackSeen;
    logic        prevAsN;
    logic        termOn;
    logic [1:0]  waitCnt;
    logic        useSterm;
    int          cycleIdx  = 0;
    int          doneCount = 0;
    int          monErrors = 0;

    // Expectations of the running transfer
    busAddr_t expBase   = '0;
    logic     expRead   = 1'b0;
    int       cycleBase = 0;
    int       doneBase  = 0;
    int       errCount  = 0;
    int       toCount   = 0;

    always #20 clk = ~clk;

    sdmacCpuTop sdmacCpuTop_inst (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .dirRead    (dirRead),
        .startAddr  (startAddr),
        .startCount (startCount),
        .scsiPush   (scsiPush),
        .scsiWrData (scsiWrData),
        .scsiPop    (scsiPop),
        .scsiRdData (scsiRdData),
        .bgN        (bgN),
        .dsackN     (dsackN),
        .stermN     (stermN),
        .rdData     (rdData),
        .breqN      (breqN),
        .bgackN     (bgackN),
        .asN        (asN),
        .dsN        (dsN),
        .rw         (rw),
        .addr       (addr),
        .wrData     (wrData),
        .done       (done),
        .fifoFull   (fifoFull),
        .fifoEmpty  (fifoEmpty)
    );

    // Memory content for any byte address mixes in every address bit
    function automatic dataWord_t expectedWord(input busAddr_t a);
        return (a * 32'h9e37_79b9) ^ {a[7:0], a[31:8]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic checkWord(input string name, input dataWord_t got, input dataWord_t exp,
                             inout int errs);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input busAddr_t got, input busAddr_t exp,
                             inout int errs);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp,
                            inout int errs);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input wordCount_t got, input wordCount_t exp,
                              inout int errs);
        if (got !== exp) begin
            errs++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Arbiter, slave and bus monitor on the falling edge
    always @(negedge clk) begin : busModel
        busAddr_t expAddr;
        int i;
        if (!rstN) begin
            for (i = 0; i < 256; i++) begin
                mem[i] = expectedWord(busAddr_t'(i * 4));
            end
            grantState = 0;
            ackSeen    = 1'b0;
            prevAsN    = 1'b1;
            termOn     = 1'b0;
            waitCnt    = 2'd0;
            useSterm   = 1'b0;
            bgN    <= 1'b1;
            dsackN <= 1'b1;
            stermN <= 1'b1;
        end else begin
            rdData <= mem[addr[9:2]];
            if (done) begin
                doneCount++;
            end
            // Grant after 0 to 3 cycles and hold bgN until bgackN is released
            case (grantState)
                0: begin
                    if (!breqN) begin
                        randVal    = $random(seed);
                        grantDelay = randVal[1:0];
                        if (grantDelay == 2'd0) begin
                            bgN <= 1'b0;
                            grantState = 2;
                        end else begin
                            grantState = 1;
                        end
                    end
                end
                1: begin
                    grantDelay = grantDelay - 2'd1;
                    if (grantDelay == 2'd0) begin
                        bgN <= 1'b0;
                        grantState = 2;
                    end
                end
                default: begin
                    if (!bgackN) begin
                        ackSeen = 1'b1;
                    end else if (ackSeen) begin
                        bgN <= 1'b1;
                        ackSeen    = 1'b0;
                        grantState = 0;
                    end
                end
            endcase
            // Start of a bus cycle
            if (!asN && prevAsN) begin
                expAddr = expBase + busAddr_t'(4 * (cycleIdx - cycleBase));
                checkBit("bgN at asN fall", bgN, 1'b0, monErrors);
                checkBit("bgackN at asN fall", bgackN, 1'b0, monErrors);
                checkAddr("addr", addr, expAddr, monErrors);
                checkBit("rw", rw, expRead, monErrors);
                if (!expRead) begin
                    checkWord("wrData", wrData, expectedWord(expAddr), monErrors);
                    mem[addr[9:2]] = wrData;
                end
                cycleIdx++;
                randVal  = $random(seed);
                waitCnt  = randVal[1:0];
                useSterm = randVal[2];
            end
            // Terminate after the wait cycles and hold until asN rises
            if (!asN && !termOn) begin
                if (waitCnt == 2'd0) begin
                    termOn = 1'b1;
                    if (useSterm) begin
                        stermN <= 1'b0;
                    end else begin
                        dsackN <= 1'b0;
                    end
                end else begin
                    waitCnt = waitCnt - 2'd1;
                end
            end
            if (asN && termOn) begin
                termOn = 1'b0;
                stermN <= 1'b1;
                dsackN <= 1'b1;
            end
            prevAsN = asN;
        end
    end

    task automatic pushWord(input dataWord_t d);
        @(negedge clk);
        scsiPush   = 1'b1;
        scsiWrData = d;
        @(negedge clk);
        scsiPush = 1'b0;
    endtask

    // Head word compared before it is popped
    task automatic popCheck(input dataWord_t exp);
        @(negedge clk);
        checkWord("scsiRdData", scsiRdData, exp, errCount);
        scsiPop = 1'b1;
        @(negedge clk);
        scsiPop = 1'b0;
    endtask

    task automatic issueStart(input logic rd, input busAddr_t base, input wordCount_t n);
        @(negedge clk);
        start      = 1'b1;
        dirRead    = rd;
        startAddr  = base;
        startCount = n;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic startXfer(input logic rd, input busAddr_t base, input wordCount_t n);
        expBase   = base;
        expRead   = rd;
        cycleBase = cycleIdx;
        doneBase  = doneCount;
        issueStart(rd, base, n);
    endtask

    task automatic waitDone(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            toCount++;
            $display("Timeout: no done strobe within %0d cycles", limit);
        end
    endtask

    task automatic waitCycles(input int count, input int limit);
        int n;
        n = 0;
        while ((cycleIdx - cycleBase) < count && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((cycleIdx - cycleBase) < count) begin
            toCount++;
            $display("Timeout: fewer than %0d bus cycles within %0d cycles", count, limit);
        end
    endtask

    task automatic waitBgackHigh(input int limit);
        int n;
        n = 0;
        while (!bgackN && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!bgackN) begin
            toCount++;
            $display("Timeout: bus not released within %0d cycles", limit);
        end
    endtask

    task automatic waitBreqLow(input int limit);
        int n;
        n = 0;
        while (breqN && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (breqN) begin
            toCount++;
            $display("Timeout: bus not requested again within %0d cycles", limit);
        end
    endtask

    // Let the FSM settle and count bus cycles and done pulses of the transfer
    task automatic finishXfer(input wordCount_t n);
        repeat (4) @(negedge clk);
        checkCount("bus cycles", wordCount_t'(cycleIdx - cycleBase), n, errCount);
        checkCount("done pulses", wordCount_t'(doneCount - doneBase), 16'd1, errCount);
    endtask

    task automatic runWrite(input busAddr_t base, input wordCount_t n);
        int i;
        for (i = 0; i < int'(n); i++) begin
            pushWord(expectedWord(base + busAddr_t'(4 * i)));
        end
        startXfer(1'b0, base, n);
        waitDone(500);
        finishXfer(n);
    endtask

    task automatic runRead(input busAddr_t base, input wordCount_t n);
        int i;
        startXfer(1'b1, base, n);
        waitDone(500);
        finishXfer(n);
        // Every word read stays in the FIFO until popped
        checkBit("fifoFull", fifoFull, int'(n) >= FIFO_DEPTH, errCount);
        for (i = 0; i < int'(n); i++) begin
            popCheck(expectedWord(base + busAddr_t'(4 * i)));
        end
        checkBit("fifoEmpty", fifoEmpty, 1'b1, errCount);
    endtask

    initial begin
        int i;
        int k;
        int totalErr;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        // Idle bus after reset
        checkBit("breqN", breqN, 1'b1, errCount);
        checkBit("bgackN", bgackN, 1'b1, errCount);
        checkBit("asN", asN, 1'b1, errCount);
        checkBit("dsN", dsN, 1'b1, errCount);
        checkBit("rw", rw, 1'b1, errCount);
        checkBit("done", done, 1'b0, errCount);
        checkBit("fifoEmpty", fifoEmpty, 1'b1, errCount);
        checkBit("fifoFull", fifoFull, 1'b0, errCount);

        runWrite(32'h0000_0100, 16'd6);
        runRead(32'h0000_0200, 16'd8);

        // Mixed dsackN and stermN answers over several transfers
        for (k = 0; k < 4; k++) begin
            runWrite(32'h0000_0280 + busAddr_t'(32'h40 * k), 16'd5);
            runRead(32'h0000_0300 + busAddr_t'(32'h40 * k), 16'd7);
        end

        // FIFO runs dry after 4 of 12 words
        for (i = 0; i < 4; i++) begin
            pushWord(expectedWord(32'h0000_0040 + busAddr_t'(4 * i)));
        end
        startXfer(1'b0, 32'h0000_0040, 16'd12);
        waitCycles(4, 300);
        waitBgackHigh(300);
        checkCount("cycles before release", wordCount_t'(cycleIdx - cycleBase), 16'd4,
                   errCount);
        checkBit("breqN while FIFO empty", breqN, 1'b1, errCount);
        pushWord(expectedWord(32'h0000_0050));
        waitBreqLow(100);
        for (i = 5; i < 12; i++) begin
            pushWord(expectedWord(32'h0000_0040 + busAddr_t'(4 * i)));
        end
        waitDone(500);
        finishXfer(16'd12);

        // Second start in the middle of a write is dropped
        for (i = 0; i < 6; i++) begin
            pushWord(expectedWord(32'h0000_00c0 + busAddr_t'(4 * i)));
        end
        startXfer(1'b0, 32'h0000_00c0, 16'd6);
        waitCycles(2, 300);
        issueStart(1'b1, 32'h0000_03f0, 16'd3);
        waitDone(500);
        finishXfer(16'd6);

        totalErr = errCount + monErrors;
        $display("Errors: %0d  Timeouts: %0d", totalErr, toCount);
        if (totalErr == 0 && toCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/sdmacCpuTop.sv
// CPU bus side of the DMA controller with FSM, output decoder, FIFO and address counter
`timescale 1ns/1ps

module sdmacCpuTop import cpuSmPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  logic       dirRead,
    input  busAddr_t   startAddr,
    input  wordCount_t startCount,
    input  logic       scsiPush,
    input  dataWord_t  scsiWrData,
    input  logic       scsiPop,
    output dataWord_t  scsiRdData,
    input  logic       bgN,
    input  logic       dsackN,
    input  logic       stermN,
    input  dataWord_t  rdData,
    output logic       breqN,
    output logic       bgackN,
    output logic       asN,
    output logic       dsN,
    output logic       rw,
    output busAddr_t   addr,
    output dataWord_t  wrData,
    output logic       done,
    output logic       fifoFull,
    output logic       fifoEmpty
);

    logic incFifo;
    logic decFifo;
    logic incAddr;
    logic wordsLeftZero;

    // Term bundle between FSM and decoder
    cpuSmTermsIf terms ();

    cpuSm cpuSm_inst (
        .clk           (clk),
        .rstN          (rstN),
        .start         (start),
        .dirRead       (dirRead),
        .wordsLeftZero (wordsLeftZero),
        .fifoFull      (fifoFull),
        .fifoEmpty     (fifoEmpty),
        .bgN           (bgN),
        .dsackN        (dsackN),
        .stermN        (stermN),
        .done          (done),
        .terms         (terms.sm)
    );

    cpuSmOutputs cpuSmOutputs_inst (
        .clk     (clk),
        .rstN    (rstN),
        .terms   (terms.dec),
        .asN     (asN),
        .dsN     (dsN),
        .rw      (rw),
        .breqN   (breqN),
        .bgackN  (bgackN),
        .incFifo (incFifo),
        .decFifo (decFifo),
        .incAddr (incAddr)
    );

    dmaFifo dmaFifo_inst (
        .clk        (clk),
        .rstN       (rstN),
        .scsiPush   (scsiPush),
        .scsiWrData (scsiWrData),
        .scsiPop    (scsiPop),
        .scsiRdData (scsiRdData),
        .incFifo    (incFifo),
        .decFifo    (decFifo),
        .busRdData  (rdData),
        .busWrData  (wrData),
        .fifoFull   (fifoFull),
        .fifoEmpty  (fifoEmpty)
    );

    addrCounter addrCounter_inst (
        .clk           (clk),
        .rstN          (rstN),
        .start         (start),
        .startAddr     (startAddr),
        .startCount    (startCount),
        .incAddr       (incAddr),
        .addr          (addr),
        .wordsLeftZero (wordsLeftZero)
    );

endmodule

//--- verilog/addrCounter.sv
// Transfer address register and remaining word counter
`timescale 1ns/1ps

module addrCounter import cpuSmPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  busAddr_t   startAddr,
    input  wordCount_t startCount,
    input  logic       incAddr,
    output busAddr_t   addr,
    output logic       wordsLeftZero
);

    wordCount_t count;
    // Tracks the two cycles the FSM still needs after the last word
    logic [1:0] recentInc;
    logic load;

    assign wordsLeftZero = (count == '0);

    // A running transfer keeps the count nonzero, so starts are ignored then
    assign load = start & wordsLeftZero & ~(|recentInc);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count     <= '0;
            recentInc <= '0;
        end else begin
            recentInc <= {recentInc[0], incAddr};
            if (load) begin
                count <= startCount;
            end else if (incAddr && !wordsLeftZero) begin
                count <= count - wordCount_t'(1);
            end
        end
    end

    // Full 32-bit words only, so step by four bytes
    always_ff @(posedge clk) begin
        if (load) begin
            addr <= startAddr;
        end else if (incAddr) begin
            addr <= addr + busAddr_t'(4);
        end
    end

endmodule

//--- verilog/dmaFifo.sv
// Eight word circular FIFO between the SCSI side and the CPU bus, with bus read capture
`timescale 1ns/1ps

module dmaFifo import cpuSmPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      scsiPush,
    input  dataWord_t scsiWrData,
    input  logic      scsiPop,
    output dataWord_t scsiRdData,
    input  logic      incFifo,
    input  logic      decFifo,
    input  dataWord_t busRdData,
    output dataWord_t busWrData,
    output logic      fifoFull,
    output logic      fifoEmpty
);

    dataWord_t mem [FIFO_DEPTH];
    // Bus data as seen on the termination edge
    dataWord_t busCapture;
    dataWord_t pushData;
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    fifoLevel_t level;
    logic pushEn;
    logic popEn;

    assign fifoFull  = (level == fifoLevel_t'(FIFO_DEPTH));
    assign fifoEmpty = (level == '0);

    // Push into full and pop from empty are dropped
    assign pushEn   = (scsiPush | incFifo) & ~fifoFull;
    assign popEn    = (scsiPop | decFifo) & ~fifoEmpty;
    assign pushData = incFifo ? busCapture : scsiWrData;

    // Head word feeds both sides
    assign scsiRdData = mem[rdPtr];
    assign busWrData  = mem[rdPtr];

    always_ff @(posedge clk) begin
        busCapture <= busRdData;
        if (pushEn) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop keep the level
            case ({pushEn, popEn})
                2'b10:   level <= level + fifoLevel_t'(1);
                2'b01:   level <= level - fifoLevel_t'(1);
                default: level <= level;
            endcase
        end
    end

endmodule

//--- verilog/cpuSmOutputs.sv
// Registered decoder from product terms and termination to bus, FIFO and arbitration strobes
`timescale 1ns/1ps

module cpuSmOutputs import cpuSmPkg::*; (
    input  logic clk,
    input  logic rstN,
    cpuSmTermsIf.dec terms,
    output logic asN,
    output logic dsN,
    output logic rw,
    output logic breqN,
    output logic bgackN,
    output logic incFifo,
    output logic decFifo,
    output logic incAddr
);

    logic nextAsN;
    logic nextDsN;
    logic nextRw;
    logic nextBreqN;
    logic nextBgackN;
    logic nextIncFifo;
    logic nextDecFifo;
    logic nextIncAddr;
    logic dsackEnd;
    logic incFifoX;
    logic incFifoY;
    logic decFifoX;
    logic decFifoY;
    logic grantPending;

    // Address strobe through address phase, hold and wait
    assign nextAsN = terms.nE[T_RD_ADDR] & terms.nE[T_WR_ADDR] & terms.nE[T_HOLD]
                   & terms.nE[T_RD_WAIT] & terms.nE[T_WR_WAIT];

    // Data strobe one cycle behind asN
    assign nextDsN = terms.nE[T_RD_WAIT] & terms.nE[T_WR_WAIT];

    // Write keeps rw low across the idle cycle of back-to-back writes
    assign nextRw = terms.nE[T_WR_ADDR] & terms.nE[T_WR_WAIT] & terms.nE[T_WR_END]
                  & ~(terms.e[T_HOLD] & ~terms.dirRead);

    // Request held until the grant edge
    assign grantPending = (terms.state == GRANTWAIT) & terms.nE[T_GRANT];
    assign nextBreqN    = terms.nE[T_REQ] & ~grantPending;

    // Bus owned from grant through the last ENDCYC
    assign nextBgackN = terms.nE[T_GRANT]
                      & terms.nE[T_RD_ADDR] & terms.nE[T_WR_ADDR] & terms.nE[T_HOLD]
                      & terms.nE[T_RD_WAIT] & terms.nE[T_WR_WAIT]
                      & terms.nE[T_RD_END] & terms.nE[T_WR_END];

    // sterm takes priority, dsack only counts without it
    assign dsackEnd = terms.dsack & terms.nSterm;

    // Read path, word written into FIFO from the bus capture
    assign incFifoX    = terms.e[T_RD_WAIT] & terms.sterm;
    assign incFifoY    = terms.e[T_RD_WAIT] & dsackEnd;
    assign nextIncFifo = incFifoX | incFifoY;

    // Write path, head word popped once the slave took it
    assign decFifoX    = terms.e[T_WR_WAIT] & terms.sterm;
    assign decFifoY    = terms.e[T_WR_WAIT] & dsackEnd;
    assign nextDecFifo = decFifoX | decFifoY;

    // Any terminated wait advances address and count
    assign nextIncAddr = (terms.e[T_RD_WAIT] | terms.e[T_WR_WAIT])
                       & ~(terms.nSterm & terms.nDsack);

    // All pins registered so the bus sees clean edges
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            asN     <= 1'b1;
            dsN     <= 1'b1;
            rw      <= 1'b1;
            breqN   <= 1'b1;
            bgackN  <= 1'b1;
            incFifo <= 1'b0;
            decFifo <= 1'b0;
            incAddr <= 1'b0;
        end else begin
            asN     <= nextAsN;
            dsN     <= nextDsN;
            rw      <= nextRw;
            breqN   <= nextBreqN;
            bgackN  <= nextBgackN;
            incFifo <= nextIncFifo;
            decFifo <= nextDecFifo;
            incAddr <= nextIncAddr;
        end
    end

endmodule

//--- verilog/cpuSm.sv
// Bus master FSM with dsack synchronizer, direction latch and product term expansion
`timescale 1ns/1ps

module cpuSm import cpuSmPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic dirRead,
    input  logic wordsLeftZero,
    input  logic fifoFull,
    input  logic fifoEmpty,
    input  logic bgN,
    input  logic dsackN,
    input  logic stermN,
    output logic done,
    cpuSmTermsIf.sm terms
);

    cpuState_e state;
    cpuState_e stateNext;
    logic [1:0] dsackSync;
    logic dirReg;
    logic prevEnd;
    logic dsack;
    logic sterm;
    logic termSeen;
    logic fifoOk;
    logic go;
    termVec_t e;

    // Two flop synchronizer, held negated outside WAIT
    // so a slow dsackN release never ends the next cycle early
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dsackSync <= 2'b11;
        end else if (state != WAIT) begin
            dsackSync <= 2'b11;
        end else begin
            dsackSync <= {dsackSync[0], dsackN};
        end
    end

    assign dsack    = ~dsackSync[1];
    // stermN is sampled straight on the edge
    assign sterm    = ~stermN;
    assign termSeen = sterm | dsack;

    // Reads need room, writes need a word
    assign fifoOk = dirReg ? ~fifoFull : ~fifoEmpty;
    assign go     = ~wordsLeftZero & fifoOk;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            dirReg  <= 1'b1;
            prevEnd <= 1'b0;
            done    <= 1'b0;
        end else begin
            state   <= stateNext;
            prevEnd <= (state == ENDCYC);
            done    <= e[T_DONE];
            // Direction only taken when a transfer is accepted
            if ((state == IDLE) && start) begin
                dirReg <= dirRead;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (start) begin
                    stateNext = REQUEST;
                end
            end
            REQUEST: begin
                if (wordsLeftZero) begin
                    stateNext = DONE;
                end else if (fifoOk) begin
                    stateNext = GRANTWAIT;
                end
            end
            GRANTWAIT: begin
                if (!bgN) begin
                    stateNext = ADDR;
                end
            end
            ADDR: begin
                if (go) begin
                    stateNext = WAIT;
                end else if (wordsLeftZero) begin
                    stateNext = DONE;
                end else begin
                    stateNext = RELEASE;
                end
            end
            WAIT: begin
                if (termSeen) begin
                    stateNext = ENDCYC;
                end
            end
            ENDCYC:  stateNext = ADDR;
            RELEASE: stateNext = REQUEST;
            DONE:    stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    // One product term per decoded condition, mutually exclusive
    always_comb begin
        e = '0;
        e[T_IDLE]    = (state == IDLE) & ~start;
        e[T_REQ]     = ((state == IDLE) & start) | ((state == REQUEST) & go);
        e[T_GRANT]   = (state == GRANTWAIT) & ~bgN;
        // First cycle after grant
        e[T_RD_ADDR] = (state == ADDR) & go & ~prevEnd & dirReg;
        e[T_WR_ADDR] = (state == ADDR) & go & ~prevEnd & ~dirReg;
        // Idle cycle between back-to-back cycles
        e[T_HOLD]    = (state == ADDR) & go & prevEnd;
        e[T_RD_WAIT] = (state == WAIT) & dirReg;
        e[T_WR_WAIT] = (state == WAIT) & ~dirReg;
        e[T_RD_END]  = (state == ENDCYC) & dirReg;
        e[T_WR_END]  = (state == ENDCYC) & ~dirReg;
        e[T_RELEASE] = (state == ADDR) & ~wordsLeftZero & ~fifoOk;
        e[T_DONE]    = ((state == ADDR) | (state == REQUEST)) & wordsLeftZero;
    end

    assign terms.state   = state;
    assign terms.e       = e;
    assign terms.nE      = ~e;
    assign terms.dsack   = dsack;
    assign terms.nDsack  = ~dsack;
    assign terms.sterm   = sterm;
    assign terms.nSterm  = stermN;
    assign terms.dirRead = dirReg;

endmodule

//--- verilog/cpuSmTermsIf.sv
// Term bundle from the bus master state machine to its registered output decoder
`timescale 1ns/1ps

interface cpuSmTermsIf import cpuSmPkg::*; ();

    // Current state, decoded directly for the grant wait
    cpuState_e state;

    // Product terms and their complement
    termVec_t e;
    termVec_t nE;

    // Synchronized asynchronous termination, both polarities
    logic dsack;
    logic nDsack;

    // Synchronous termination as sampled on the edge
    logic sterm;
    logic nSterm;

    // Latched direction, 1 moves memory to FIFO
    logic dirRead;

    modport sm (
        output state, e, nE, dsack, nDsack, sterm, nSterm, dirRead
    );

    modport dec (
        input state, e, nE, dsack, nDsack, sterm, nSterm, dirRead
    );

endinterface

//--- verilog/cpuSmPkg.sv
// Shared widths, FIFO depth, product term indices and state encoding of the bus master
package cpuSmPkg;

    // FIFO geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // One bit per product term of the state decoder
    localparam int NUM_TERMS = 12;

    typedef logic [31:0] dataWord_t;
    typedef logic [31:0] busAddr_t;
    typedef logic [15:0] wordCount_t;
    // Holds 0 up to FIFO_DEPTH inclusive
    typedef logic [3:0] fifoLevel_t;
    typedef logic [NUM_TERMS-1:0] termVec_t;

    // Product term positions in e and nE
    localparam int T_IDLE    = 0;
    localparam int T_REQ     = 1;
    localparam int T_GRANT   = 2;
    localparam int T_RD_ADDR = 3;
    localparam int T_WR_ADDR = 4;
    localparam int T_RD_WAIT = 5;
    localparam int T_WR_WAIT = 6;
    localparam int T_RD_END  = 7;
    localparam int T_WR_END  = 8;
    localparam int T_RELEASE = 9;
    localparam int T_DONE    = 10;
    localparam int T_HOLD    = 11;

    // Bus master states
    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        REQUEST   = 4'd1,
        GRANTWAIT = 4'd2,
        ADDR      = 4'd3,
        WAIT      = 4'd4,
        ENDCYC    = 4'd5,
        RELEASE   = 4'd6,
        DONE      = 4'd7
    } cpuState_e;

endpackage
